//--- list.f
+incdir+design
design/rx_data_pkg.sv
design/rx_ctrl_pkg.sv
design/rx_que_fifo.sv
design/rx_rr_arb.sv
design/rx_sched_fsm.sv
design/rx_stall_timer.sv
design/rx_hdr_build.sv
design/rx_pkt_top.sv
verification/rx_pkt_asserts.sv
verification/rx_pkt_tb.sv

//--- Makefile
TOOL       = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = rx_pkt_tb
RTL_TOP    = rx_pkt_top
FLIST      = list.f
OBJ        = obj_dir
LOG        = sim.log
FAIL_MSG   = Verification failed
PASS_MSG   = Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --Mdir $(OBJ) --top-module $(TOP) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without passing"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

//--- verification/rx_pkt_tb.sv
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_pkt_tb import rx_data_pkg::*, rx_ctrl_pkg::*; ();

    localparam int MODE_NORMAL = 0;
    localparam int MODE_GAP    = 1;
    localparam int MODE_STALL  = 2;
    localparam int MODE_OVF    = 3;
    localparam int NUM_ROWS    = 7;
    localparam int WAIT_LIMIT  = 2000;

    logic                    clk_sys;
    logic                    rst;
    que_vec_t                que_wr;
    word_t [`RX_QUE_NUM-1:0] que_wdata;
    que_vec_t                que_wlast;
    logic                    base_wr;
    que_id_t                 base_que;
    dst_addr_t               base_addr;
    logic                    tmout_en;
    tmout_cnt_t              tmout_limit;
    logic                    out_valid;
    word_t                   out_data;
    logic                    out_first;
    logic                    out_last;
    que_vec_t                stall_err;
    que_vec_t                ovf_err;

    // stall and overflow rows use the lowest mask bit as the holding queue
    int stim_tab [NUM_ROWS][6] = '{
        // mode       mask     len  load que address
        '{MODE_NORMAL, 'b1000, 4,   1,   3,  'h0001_0000},
        '{MODE_NORMAL, 'b1111, 3,   1,   0,  'h0000_0100},
        '{MODE_NORMAL, 'b1111, 5,   0,   0,  0},
        '{MODE_NORMAL, 'b0001, 6,   0,   0,  0},
        '{MODE_GAP,    'b0010, 5,   1,   1,  'h3fff_fff0},
        '{MODE_STALL,  'b0011, 4,   0,   0,  0},
        '{MODE_OVF,    'b0110, 3,   1,   2,  'h0000_2000}
    };

    // scoreboard, one word queue per source plus the expected header order
    logic [`RX_WORD_W:0] exp_words [`RX_QUE_NUM][$];
    int                  exp_len [`RX_QUE_NUM][$];
    int                  exp_order [$];
    dst_addr_t           model_addr [`RX_QUE_NUM];
    int                  rr_last;
    int                  hdr_count;
    int                  cur_que;
    int                  err_cnt;
    int                  mon_q;
    logic [`RX_WORD_W:0] mon_entry;

    rx_pkt_top rx_pkt_top_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .que_wr      (que_wr),
        .que_wdata   (que_wdata),
        .que_wlast   (que_wlast),
        .base_wr     (base_wr),
        .base_que    (base_que),
        .base_addr   (base_addr),
        .tmout_en    (tmout_en),
        .tmout_limit (tmout_limit),
        .out_valid   (out_valid),
        .out_data    (out_data),
        .out_first   (out_first),
        .out_last    (out_last),
        .stall_err   (stall_err),
        .ovf_err     (ovf_err)
    );

    bind rx_pkt_top rx_pkt_asserts rx_pkt_asserts_inst (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .out_valid (out_valid),
        .out_first (out_first),
        .out_last  (out_last),
        .que_pop   (que_pop),
        .que_empty (que_empty)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    // ========================================
    // reporting
    // ========================================

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            stop_run();
        end
    endtask

    // ========================================
    // stimulus
    // ========================================

    task automatic next_cycle();
        @(posedge clk_sys);
        #5;
    endtask

    task automatic load_base(input que_id_t que, input dst_addr_t addr);
        next_cycle();
        base_wr   = 1'b1;
        base_que  = que;
        base_addr = addr;
        model_addr[que] = addr;
        next_cycle();
        base_wr = 1'b0;
    endtask

    // words first..first+count-1 of a len-word packet, keep=0 for dropped words
    task automatic write_words(input que_vec_t mask, input int first, input int count,
                               input int len, input int gap, input bit keep);
        word_t w;
        bit    is_last;
        for (int i = first; i < first + count; i++) begin
            next_cycle();
            is_last   = (i == len - 1);
            que_wr    = mask;
            que_wlast = is_last ? mask : '0;
            for (int q = 0; q < `RX_QUE_NUM; q++) begin
                w = $urandom();
                que_wdata[q] = w;
                if (mask[q] && keep) begin
                    if (i == 0) begin
                        exp_len[q].push_back(len);
                    end
                    exp_words[q].push_back({is_last, w});
                end
            end
            // slow source leaves idle cycles between words
            for (int g = 0; g < gap; g++) begin
                next_cycle();
                que_wr    = '0;
                que_wlast = '0;
            end
        end
        next_cycle();
        que_wr    = '0;
        que_wlast = '0;
    endtask

    task automatic push_rr_order(input que_vec_t mask);
        int start;
        int q;
        start = rr_last;
        for (int i = 1; i <= `RX_QUE_NUM; i++) begin
            q = (start + i) % `RX_QUE_NUM;
            if (mask[q]) begin
                exp_order.push_back(q);
                rr_last = q;
            end
        end
    endtask

    function automatic int low_que(input que_vec_t mask);
        int idx;
        idx = 0;
        for (int q = `RX_QUE_NUM - 1; q >= 0; q--) begin
            if (mask[q]) begin
                idx = q;
            end
        end
        return idx;
    endfunction

    function automatic int high_que(input que_vec_t mask);
        int idx;
        idx = 0;
        for (int q = 0; q < `RX_QUE_NUM; q++) begin
            if (mask[q]) begin
                idx = q;
            end
        end
        return idx;
    endfunction

    function automatic bit all_drained();
        bit done;
        done = (exp_order.size() == 0);
        for (int q = 0; q < `RX_QUE_NUM; q++) begin
            if (exp_words[q].size() != 0) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    // ========================================
    // wait loops
    // ========================================

    task automatic wait_headers(input int target);
        int n;
        n = 0;
        while (hdr_count < target && n < WAIT_LIMIT) begin
            @(negedge clk_sys);
            n++;
        end
        if (hdr_count < target) begin
            report_failure("timeout waiting for a packet header");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (!all_drained() && n < WAIT_LIMIT) begin
            @(negedge clk_sys);
            n++;
        end
        if (!all_drained()) begin
            report_failure("timeout waiting for the expected packets to come out");
        end
    endtask

    task automatic wait_stall(input int que, input logic level);
        int n;
        n = 0;
        while (stall_err[que] !== level && n < WAIT_LIMIT) begin
            @(negedge clk_sys);
            n++;
        end
        if (stall_err[que] !== level) begin
            report_failure("timeout waiting for stall_err to change");
        end
    endtask

    // ========================================
    // special rows
    // ========================================

    task automatic run_stall(input que_vec_t mask, input int len);
        int hold;
        int other;
        int hdr_target;
        hold  = low_que(mask);
        other = high_que(mask);
        next_cycle();
        tmout_limit = 8'd3;
        tmout_en    = 1'b1;
        exp_order.push_back(hold);
        exp_order.push_back(other);
        hdr_target = hdr_count + 1;
        // partial packet parks the scheduler on the holding queue
        write_words(que_vec_t'(1 << hold), 0, len - 1, len, 0, 1'b1);
        wait_headers(hdr_target);
        write_words(que_vec_t'(1 << other), 0, len, len, 0, 1'b1);
        wait_stall(other, 1'b1);
        check_val("stall_err", 64'(stall_err), 64'(1 << other));
        write_words(que_vec_t'(1 << hold), len - 1, 1, len, 0, 1'b1);
        wait_drain();
        wait_stall(other, 1'b0);
        next_cycle();
        tmout_en = 1'b0;
        rr_last  = other;
    endtask

    task automatic run_overflow(input que_vec_t mask, input int len);
        int hold;
        int other;
        int hdr_target;
        hold  = low_que(mask);
        other = high_que(mask);
        exp_order.push_back(hold);
        exp_order.push_back(other);
        hdr_target = hdr_count + 1;
        write_words(que_vec_t'(1 << hold), 0, len - 1, len, 0, 1'b1);
        wait_headers(hdr_target);
        // a full packet then one word more than the FIFO holds
        write_words(que_vec_t'(1 << other), 0, `RX_FIFO_DEPTH, `RX_FIFO_DEPTH, 0, 1'b1);
        write_words(que_vec_t'(1 << other), 0, 1, 1, 0, 1'b0);
        check_val("ovf_err", 64'(ovf_err), 64'(1 << other));
        write_words(que_vec_t'(1 << hold), len - 1, 1, len, 0, 1'b1);
        wait_drain();
        rr_last = other;
    endtask

    // ========================================
    // output monitor
    // ========================================

    always @(negedge clk_sys) begin
        if (!rst && out_valid) begin
            if (out_first) begin
                if (exp_order.size() == 0) begin
                    report_failure("header seen while no packet was expected");
                end else begin
                    mon_q = exp_order.pop_front();
                    if (exp_len[mon_q].size() == 0) begin
                        report_failure("header seen for a queue with no packet written");
                    end else begin
                        check_val("out_data", 64'(out_data),
                                  64'({que_id_t'(mon_q), model_addr[mon_q]}));
                        check_val("out_last", 64'(out_last), 64'(0));
                        model_addr[mon_q] = model_addr[mon_q]
                                            + dst_addr_t'(4 * exp_len[mon_q].pop_front());
                        cur_que = mon_q;
                        hdr_count++;
                    end
                end
            end else begin
                if (exp_words[cur_que].size() == 0) begin
                    report_failure("data word seen while none was expected");
                end else begin
                    mon_entry = exp_words[cur_que].pop_front();
                    check_val("out_data", 64'(out_data), 64'(mon_entry[`RX_WORD_W-1:0]));
                    check_val("out_last", 64'(out_last), 64'(mon_entry[`RX_WORD_W]));
                end
            end
        end
    end

    // ========================================
    // main sequence
    // ========================================

    initial begin
        int unsigned seed_ret;
        que_vec_t    mask;
        int          mode;
        int          len;
        seed_ret    = $urandom(32'h10f);
        rst         = 1'b1;
        que_wr      = '0;
        que_wdata   = '0;
        que_wlast   = '0;
        base_wr     = 1'b0;
        base_que    = '0;
        base_addr   = '0;
        tmout_en    = 1'b0;
        tmout_limit = '0;
        err_cnt     = 0;
        hdr_count   = 0;
        cur_que     = 0;
        rr_last     = `RX_QUE_NUM - 1;
        for (int q = 0; q < `RX_QUE_NUM; q++) begin
            model_addr[q] = '0;
        end
        repeat (8) @(posedge clk_sys);
        #5;
        rst = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            mode = stim_tab[r][0];
            mask = que_vec_t'(stim_tab[r][1]);
            len  = stim_tab[r][2];
            if (stim_tab[r][3] != 0) begin
                load_base(que_id_t'(stim_tab[r][4]), dst_addr_t'(stim_tab[r][5]));
            end
            case (mode)
                MODE_STALL: begin
                    run_stall(mask, len);
                end
                MODE_OVF: begin
                    run_overflow(mask, len);
                end
                default: begin
                    push_rr_order(mask);
                    write_words(mask, 0, len, len, (mode == MODE_GAP) ? 3 : 0, 1'b1);
                end
            endcase
            wait_drain();
        end

        repeat (4) @(posedge clk_sys);
        if (err_cnt == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_run();
        end
    end

endmodule

//--- verification/rx_pkt_asserts.sv
`timescale 1ns/1ps

module rx_pkt_asserts import rx_data_pkg::*; (
    input logic     clk_sys,
    input logic     rst,
    input logic     out_valid,
    input logic     out_first,
    input logic     out_last,
    input que_vec_t que_pop,
    input que_vec_t que_empty
);

    // header and end markers only ride on a valid word
    first_with_valid: assert property (
        @(posedge clk_sys) disable iff (rst) out_first |-> out_valid
    ) else $error("out_first high without out_valid");

    last_with_valid: assert property (
        @(posedge clk_sys) disable iff (rst) out_last |-> out_valid
    ) else $error("out_last high without out_valid");

    // scheduler serves one queue at a time
    pop_onehot: assert property (
        @(posedge clk_sys) disable iff (rst) $onehot0(que_pop)
    ) else $error("que_pop has more than one bit set");

    pop_not_empty: assert property (
        @(posedge clk_sys) disable iff (rst) (que_pop & que_empty) == '0
    ) else $error("pop strobe on an empty queue FIFO");

endmodule

//--- design/rx_pkt_top.sv
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_pkt_top import rx_data_pkg::*, rx_ctrl_pkg::*; (
    input  logic                    clk_sys,
    input  logic                    rst,
    input  que_vec_t                que_wr,
    input  word_t [`RX_QUE_NUM-1:0] que_wdata,
    input  que_vec_t                que_wlast,
    input  logic                    base_wr,
    input  que_id_t                 base_que,
    input  dst_addr_t               base_addr,
    input  logic                    tmout_en,
    input  tmout_cnt_t              tmout_limit,
    output logic                    out_valid,
    output word_t                   out_data,
    output logic                    out_first,
    output logic                    out_last,
    output que_vec_t                stall_err,
    output que_vec_t                ovf_err
);

    que_vec_t                que_empty;
    que_vec_t                que_nonempty;
    que_vec_t                que_rlast;
    word_t [`RX_QUE_NUM-1:0] que_rdata;
    que_vec_t                que_pop;
    logic                    sched_req;
    que_id_t                 grant_que;
    logic                    grant_valid;
    logic                    hdr_emit;
    logic                    word_emit;
    logic                    word_last;
    que_id_t                 serve_que;
    logic                    serving;

    assign que_nonempty = ~que_empty;

    // one packet FIFO per source queue
    for (genvar q = 0; q < `RX_QUE_NUM; q++) begin : gen_que
        rx_que_fifo rx_que_fifo_inst (
            .clk_sys (clk_sys),
            .rst     (rst),
            .wr      (que_wr[q]),
            .wlast   (que_wlast[q]),
            .wdata   (que_wdata[q]),
            .pop     (que_pop[q]),
            .rdata   (que_rdata[q]),
            .rlast   (que_rlast[q]),
            .empty   (que_empty[q]),
            .ovf     (ovf_err[q])
        );
    end

    rx_rr_arb rx_rr_arb_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .req_vec     (que_nonempty),
        .sched_req   (sched_req),
        .grant_que   (grant_que),
        .grant_valid (grant_valid)
    );

    rx_sched_fsm rx_sched_fsm_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .nonempty    (que_nonempty),
        .head_last   (que_rlast),
        .grant_que   (grant_que),
        .grant_valid (grant_valid),
        .sched_req   (sched_req),
        .que_pop     (que_pop),
        .hdr_emit    (hdr_emit),
        .word_emit   (word_emit),
        .word_last   (word_last),
        .serve_que   (serve_que),
        .serving     (serving)
    );

    rx_stall_timer rx_stall_timer_inst (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .nonempty    (que_nonempty),
        .serving     (serving),
        .serve_que   (serve_que),
        .tmout_en    (tmout_en),
        .tmout_limit (tmout_limit),
        .stall_err   (stall_err)
    );

    rx_hdr_build rx_hdr_build_inst (
        .clk_sys   (clk_sys),
        .rst       (rst),
        .base_wr   (base_wr),
        .base_que  (base_que),
        .base_addr (base_addr),
        .hdr_emit  (hdr_emit),
        .word_emit (word_emit),
        .word_last (word_last),
        .serve_que (serve_que),
        .head_data (que_rdata),
        .out_valid (out_valid),
        .out_first (out_first),
        .out_last  (out_last),
        .out_data  (out_data)
    );

endmodule

//--- design/rx_hdr_build.sv
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_hdr_build import rx_data_pkg::*; (
    input  logic                         clk_sys,
    input  logic                         rst,
    input  logic                         base_wr,
    input  que_id_t                      base_que,
    input  dst_addr_t                    base_addr,
    input  logic                         hdr_emit,
    input  logic                         word_emit,
    input  logic                         word_last,
    input  que_id_t                      serve_que,
    input  word_t [`RX_QUE_NUM-1:0]      head_data,
    output logic                         out_valid,
    output logic                         out_first,
    output logic                         out_last,
    output word_t                        out_data
);

    dst_addr_t dst_addr [`RX_QUE_NUM];
    pkt_len_t  len_cnt;
    pkt_len_t  len_nxt;
    word_t     hdr_word;

    // header is queue id on top of the byte address
    assign hdr_word = word_t'({serve_que, dst_addr[serve_que]});
    assign len_nxt  = len_cnt + 1'b1;

    // ========================================
    // per-queue destination address
    // ========================================

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            len_cnt <= '0;
            for (int q = 0; q < `RX_QUE_NUM; q++) begin
                dst_addr[q] <= '0;
            end
        end else begin
            if (hdr_emit || (word_emit && word_last)) begin
                len_cnt <= '0;
            end else if (word_emit) begin
                len_cnt <= len_nxt;
            end
            for (int q = 0; q < `RX_QUE_NUM; q++) begin
                // a config load wins over the end-of-packet advance
                if (base_wr && base_que == que_id_t'(q)) begin
                    dst_addr[q] <= base_addr;
                end else if (word_emit && word_last && serve_que == que_id_t'(q)) begin
                    dst_addr[q] <= dst_addr[q] + dst_addr_t'({len_nxt, 2'b00});
                end
            end
        end
    end

    // ========================================
    // output register
    // ========================================

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_first <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= hdr_emit || word_emit;
            out_first <= hdr_emit;
            out_last  <= word_emit && word_last;
        end
    end

    always_ff @(posedge clk_sys) begin
        out_data <= hdr_emit ? hdr_word : head_data[serve_que];
    end

endmodule

//--- design/rx_stall_timer.sv
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_stall_timer import rx_data_pkg::*, rx_ctrl_pkg::*; (
    input  logic       clk_sys,
    input  logic       rst,
    input  que_vec_t   nonempty,
    input  logic       serving,
    input  que_id_t    serve_que,
    input  logic       tmout_en,
    input  tmout_cnt_t tmout_limit,
    output que_vec_t   stall_err
);

    typedef logic [$clog2(`RX_TICK_DIV)-1:0] div_cnt_t;

    div_cnt_t   div_cnt;
    logic       tick;
    tmout_cnt_t wait_cnt [`RX_QUE_NUM];

    // prescaler, one tick every RX_TICK_DIV cycles
    assign tick = (div_cnt == div_cnt_t'(`RX_TICK_DIV - 1));

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= tick ? '0 : div_cnt + 1'b1;
        end
    end

    // counters stop at the limit so the compare holds until cleared
    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            for (int q = 0; q < `RX_QUE_NUM; q++) begin
                wait_cnt[q] <= '0;
            end
            stall_err <= '0;
        end else begin
            for (int q = 0; q < `RX_QUE_NUM; q++) begin
                if (!tmout_en || (serving && serve_que == que_id_t'(q))) begin
                    wait_cnt[q] <= '0;
                end else if (tick && nonempty[q] && wait_cnt[q] != tmout_limit) begin
                    wait_cnt[q] <= wait_cnt[q] + 1'b1;
                end
                stall_err[q] <= tmout_en && (tmout_limit != '0)
                                && (wait_cnt[q] == tmout_limit);
            end
        end
    end

endmodule

//--- design/rx_sched_fsm.sv
`timescale 1ns/1ps

module rx_sched_fsm import rx_data_pkg::*, rx_ctrl_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst,
    input  que_vec_t nonempty,
    input  que_vec_t head_last,
    input  que_id_t  grant_que,
    input  logic     grant_valid,
    output logic     sched_req,
    output que_vec_t que_pop,
    output logic     hdr_emit,
    output logic     word_emit,
    output logic     word_last,
    output que_id_t  serve_que,
    output logic     serving
);

    sched_state_t state;
    sched_state_t state_nxt;
    que_id_t      cur_que;
    logic         pop_ok;

    // ========================================
    // outputs
    // ========================================

    assign sched_req = (state == IDLE) && (|nonempty);
    assign hdr_emit  = (state == HEAD);

    // the body waits on a slow source, popping only when data is there
    assign pop_ok    = (state == BODY) && nonempty[cur_que];
    assign word_emit = pop_ok;
    assign word_last = pop_ok && head_last[cur_que];
    assign que_pop   = pop_ok ? (que_vec_t'(1) << cur_que) : '0;

    assign serve_que = cur_que;
    assign serving   = (state == HEAD) || (state == BODY);

    // ========================================
    // state machine
    // ========================================

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE: begin
                if (sched_req) begin
                    state_nxt = GRANT;
                end
            end
            GRANT: begin
                state_nxt = grant_valid ? HEAD : IDLE;
            end
            HEAD: begin
                state_nxt = BODY;
            end
            BODY: begin
                if (word_last) begin
                    state_nxt = IDLE;
                end
            end
            default: begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            state   <= IDLE;
            cur_que <= '0;
        end else begin
            state <= state_nxt;
            // hold the granted queue for the whole packet
            if (state == GRANT && grant_valid) begin
                cur_que <= grant_que;
            end
        end
    end

endmodule

//--- design/rx_rr_arb.sv
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_rr_arb import rx_data_pkg::*; (
    input  logic     clk_sys,
    input  logic     rst,
    input  que_vec_t req_vec,
    input  logic     sched_req,
    output que_id_t  grant_que,
    output logic     grant_valid
);

    que_id_t last_que;
    que_id_t idx;
    que_id_t pick_que;
    logic    pick_hit;

    // search starts one past the last served queue and wraps
    always_comb begin
        pick_que = last_que;
        pick_hit = 1'b0;
        idx      = last_que;
        for (int i = 1; i <= `RX_QUE_NUM; i++) begin
            idx = last_que + que_id_t'(i);
            if (!pick_hit && req_vec[idx]) begin
                pick_que = idx;
                pick_hit = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            // queue 0 gets the first turn
            last_que    <= que_id_t'(`RX_QUE_NUM - 1);
            grant_que   <= '0;
            grant_valid <= 1'b0;
        end else begin
            grant_valid <= sched_req && pick_hit;
            if (sched_req && pick_hit) begin
                grant_que <= pick_que;
                last_que  <= pick_que;
            end
        end
    end

endmodule

//--- design/rx_que_fifo.sv
`timescale 1ns/1ps
`include "rx_settings.svh"

module rx_que_fifo import rx_data_pkg::*; (
    input  logic  clk_sys,
    input  logic  rst,
    input  logic  wr,
    input  logic  wlast,
    input  word_t wdata,
    input  logic  pop,
    output word_t rdata,
    output logic  rlast,
    output logic  empty,
    output logic  ovf
);

    word_t mem [`RX_FIFO_DEPTH];
    logic  last_mem [`RX_FIFO_DEPTH];

    logic [`RX_FIFO_AW-1:0] wr_ptr;
    logic [`RX_FIFO_AW-1:0] rd_ptr;
    logic [`RX_FIFO_AW:0]   level;

    logic full;
    logic do_wr;
    logic do_pop;

    assign full   = (level == (`RX_FIFO_AW+1)'(`RX_FIFO_DEPTH));
    assign empty  = (level == '0);
    assign do_wr  = wr && !full;
    assign do_pop = pop && !empty;

    // head of queue is visible as soon as the read pointer moves
    assign rdata = mem[rd_ptr];
    assign rlast = last_mem[rd_ptr];

    always_ff @(posedge clk_sys) begin
        if (do_wr) begin
            mem[wr_ptr]      <= wdata;
            last_mem[wr_ptr] <= wlast;
        end
    end

    always_ff @(posedge clk_sys or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
            ovf    <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_wr && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_wr) begin
                level <= level - 1'b1;
            end
            // sticky until reset, the dropped word is lost
            if (wr && full) begin
                ovf <= 1'b1;
            end
        end
    end

endmodule

//--- design/rx_ctrl_pkg.sv
`include "rx_settings.svh"

package rx_ctrl_pkg;

    // scheduler states
    typedef enum logic [1:0] {
        IDLE,
        GRANT,
        HEAD,
        BODY
    } sched_state_t;

    // stall counter in timer ticks
    typedef logic [`RX_TMOUT_W-1:0] tmout_cnt_t;

endpackage

//--- design/rx_data_pkg.sv
`include "rx_settings.svh"

package rx_data_pkg;

    // one packet or header word
    typedef logic [`RX_WORD_W-1:0] word_t;

    // queue number and one-bit-per-queue vector
    typedef logic [$clog2(`RX_QUE_NUM)-1:0] que_id_t;
    typedef logic [`RX_QUE_NUM-1:0] que_vec_t;

    // byte address where the queue's next packet goes
    typedef logic [`RX_ADDR_W-1:0] dst_addr_t;

    // packet length in words, one bit wider than the FIFO address
    typedef logic [`RX_FIFO_AW:0] pkt_len_t;

endpackage

//--- design/rx_settings.svh
`ifndef RX_SETTINGS_SVH
`define RX_SETTINGS_SVH

// queue count, fixed by the 2-bit queue id
`define RX_QUE_NUM    4
`define RX_WORD_W     32

// per-queue packet FIFO
`define RX_FIFO_DEPTH 16
`define RX_FIFO_AW    4

// destination address in bytes, header keeps two bits for the queue id
`define RX_ADDR_W     30

// stall timer
`define RX_TICK_DIV   8
`define RX_TMOUT_W    8

`endif
